/* verilog.f */
source/ciPackage.sv
source/resetSequencer.sv
source/ciDispatcher.sv
source/swapByte.sv
source/processorId.sv
source/delayMicro.sv
source/or1420CiSubsystem.sv
bench/or1420CiSubsystem_sva.sv
bench/or1420CiSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = or1420CiSubsystemTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSTEXT  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASSTEXT)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/or1420CiSubsystemTb.sv */
`timescale 1ns/1ps

module or1420CiSubsystemTb import ciPackage::*; ();

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        clock50MHz;
  logic        clock12MHz;
  logic        biosBypass;
  logic        ciStart;
  ciOpcodeType ciN;
  ciWordType   ciDataA;
  ciWordType   ciDataB;
  logic        ciDone;
  logic        cpuReset;
  ciWordType   ciResult;
  int          seed;

  always #5 s_systemClock = ~s_systemClock;
  always #10 clock50MHz = ~clock50MHz;
  always #41.667 clock12MHz = ~clock12MHz;  // Close enough to 12 MHz for the delay bounds.

  or1420CiSubsystem i_or1420CiSubsystem (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .clock50MHz    (clock50MHz),
    .clock12MHz    (clock12MHz),
    .biosBypass    (biosBypass),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (ciDone),
    .cpuReset      (cpuReset),
    .ciResult      (ciResult)
  );

  bind or1420CiSubsystem or1420CiSubsystemSva i_or1420CiSubsystemSva (
    .s_systemClock (s_systemClock),
    .cpuReset      (cpuReset),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic compareWord(input string what, input ciWordType actual, input ciWordType expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("FAILED at %0t ns: %s expected %08h got %08h",
                                $time, what, expected, actual));
    end
  endtask

  task automatic compareLevel(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("FAILED at %0t ns: %s expected %b got %b",
                                $time, what, expected, actual));
    end
  endtask

  task automatic compareCount(input string what, input int actual, input int expected);
    if (actual != expected) begin
      stopWithFailure($sformatf("FAILED at %0t ns: %s expected %0d got %0d",
                                $time, what, expected, actual));
    end
  endtask

  task automatic checkWithin(input string what, input int actual, input int low, input int high);
    if (actual < low || actual > high) begin
      stopWithFailure($sformatf("FAILED at %0t ns: %s is %0d, allowed %0d to %0d",
                                $time, what, actual, low, high));
    end
  endtask

  // One instruction. Outputs are sampled 2 ns after the falling edge, well before the rise.
  task automatic issueInstruction(input ciOpcodeType opcode, input ciWordType dataA,
                                  input ciWordType dataB, input int timeoutCycles,
                                  output ciWordType result, output int latencyNs);
    int  cycles;
    time startTime;
    cycles = 0;
    @(negedge s_systemClock);
    ciStart = 1'b1;
    ciN     = opcode;
    ciDataA = dataA;
    ciDataB = dataB;
    #2;
    startTime = $time;
    while (ciDone !== 1'b1) begin
      @(negedge s_systemClock);
      ciStart = 1'b0;
      #2;
      cycles++;
      if (cycles > timeoutCycles) begin
        stopWithFailure($sformatf("Timeout: instruction %0d gave no ciDone within %0d cycles.",
                                  opcode, timeoutCycles));
      end
    end
    result    = ciResult;
    latencyNs = int'($time - startTime);
    @(negedge s_systemClock);
    ciStart = 1'b0;
  endtask

  task automatic testReset();
    int cycles;
    cycles = 0;
    repeat (8) begin
      @(negedge s_systemClock);
      compareLevel("cpuReset while the PLL is unlocked", cpuReset, 1'b1);
      compareLevel("ciDone while the PLL is unlocked", ciDone, 1'b0);
    end
    s_pllLocked = 1'b1;
    while (cpuReset === 1'b1) begin
      @(negedge s_systemClock);
      cycles++;
      compareLevel("ciDone before reset release", ciDone, 1'b0);
      if (cycles > 40) begin
        stopWithFailure("Timeout: cpuReset never fell after the PLL locked.");
      end
    end
    compareCount("system clocks from lock to reset release", cycles, 16);
  endtask

  task automatic testSwapByte();
    ciWordType dataA;
    ciWordType dataB;
    ciWordType expected;
    ciWordType result;
    int        latencyNs;
    int        index;
    int        byteIndex;
    for (index = 0; index < 8; index++) begin
      dataA    = $random(seed);
      dataB    = $random(seed);
      dataB[0] = index[0];  // Alternate between full reversal and halfword swap.
      for (byteIndex = 0; byteIndex < 4; byteIndex++) begin
        if (dataB[0] == 1'b0) begin
          expected[8*byteIndex +: 8] = dataA[8*(3 - byteIndex) +: 8];
        end else begin
          expected[8*byteIndex +: 8] = dataA[8*(byteIndex ^ 1) +: 8];
        end
      end
      issueInstruction(ciSwapByte, dataA, dataB, 4, result, latencyNs);
      compareWord("byte swap result", result, expected);
      compareCount("byte swap latency in ns", latencyNs, 0);
    end
  endtask

  task automatic testUnknownOpcode();
    ciWordType result;
    int        latencyNs;
    issueInstruction(ciOpcodeType'(8'd9), $random(seed), $random(seed), 4, result, latencyNs);
    compareWord("unknown opcode result", result, '0);
    compareCount("unknown opcode latency in ns", latencyNs, 0);
  endtask

  task automatic testFrequency();
    ciWordType result;
    int        latencyNs;
    int        attempts;
    int        freqHz;
    attempts = 0;
    result   = '0;
    while (result[27:0] == 28'd0) begin
      issueInstruction(ciCpuFreq, '0, '0, 4, result, latencyNs);
      compareCount("frequency latency in ns", latencyNs, 0);
      compareWord("identification field", result & 32'h7000_0000,
                  ciWordType'(processorIdValue) << 28);
      compareWord("bios bypass bit while low", result & 32'h8000_0000, 32'h0);
      attempts++;
      if (attempts > 60) begin
        stopWithFailure("Timeout: the frequency field stayed zero.");
      end
      repeat (100) @(negedge s_systemClock);
    end
    freqHz = {4'd0, result[27:0]};
    checkWithin("measured frequency in Hz", freqHz, 99800000, 100200000);
    biosBypass = 1'b1;
    issueInstruction(ciCpuFreq, '0, '0, 4, result, latencyNs);
    compareWord("bios bypass bit while high", result & 32'h8000_0000, 32'h8000_0000);
    compareWord("identification field", result & 32'h7000_0000,
                ciWordType'(processorIdValue) << 28);
    biosBypass = 1'b0;
  endtask

  task automatic testDelay(input int micros);
    ciWordType result;
    int        latencyNs;
    issueInstruction(ciDelay, ciWordType'(micros), '0, micros * 110 + 200, result, latencyNs);
    compareWord("delay result", result, '0);
    checkWithin($sformatf("latency in ns of a %0d us delay", micros), latencyNs,
                micros * 1000, micros * 1000 + 1030);
    if (micros == 0) begin
      compareCount("latency in ns of a zero delay", latencyNs, 10);
    end
  endtask

  initial begin
    seed          = 32'h6e45_4c60;
    s_systemClock = 1'b0;
    clock50MHz    = 1'b0;
    clock12MHz    = 1'b0;
    s_pllLocked   = 1'b0;
    biosBypass    = 1'b0;
    ciStart       = 1'b0;
    ciN           = ciSwapByte;
    ciDataA       = '0;
    ciDataB       = '0;
    testReset();
    testSwapByte();
    testUnknownOpcode();
    testFrequency();
    testDelay(0);
    testDelay(3);
    testDelay(7);
    if (i_or1420CiSubsystem.i_or1420CiSubsystemSva.assertFailCount == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stopWithFailure("An assertion on the instruction port failed.");
    end
  end

endmodule

/* bench/or1420CiSubsystem_sva.sv */
`timescale 1ns/1ps

module or1420CiSubsystemSva import ciPackage::*; (
  input logic        s_systemClock,
  input logic        cpuReset,
  input logic        ciStart,
  input ciOpcodeType ciN,
  input logic        ciDone,
  input ciWordType   ciResult
);

  int assertFailCount = 0;  // Read by the testbench at the end of the run.

  // No instruction can complete while the processor is held in reset.
  property doneQuietInReset;
    @(posedge s_systemClock) cpuReset |-> !ciDone;
  endproperty

  property swapDoneSameCycle;
    @(posedge s_systemClock) disable iff (cpuReset)
      (ciStart && ciN == ciSwapByte) |-> ciDone;
  endproperty

  // The result bus is wired-OR, so it must be clean between answers.
  property resultZeroWhenIdle;
    @(posedge s_systemClock) !ciDone |-> (ciResult == '0);
  endproperty

  doneQuietInResetCheck: assert property (doneQuietInReset) else begin
    assertFailCount++;
    $error("ciDone asserted while cpuReset is high");
  end

  swapDoneSameCycleCheck: assert property (swapDoneSameCycle) else begin
    assertFailCount++;
    $error("byte swap start without ciDone in the same cycle");
  end

  resultZeroWhenIdleCheck: assert property (resultZeroWhenIdle) else begin
    assertFailCount++;
    $error("ciResult nonzero while ciDone is low");
  end

endmodule

/* source/or1420CiSubsystem.sv */
`timescale 1ns/1ps

module or1420CiSubsystem import ciPackage::*; (
  input  logic        s_systemClock,
  input  logic        s_pllLocked,
  input  logic        clock50MHz,
  input  logic        clock12MHz,
  input  logic        biosBypass,
  input  logic        ciStart,
  input  ciOpcodeType ciN,
  input  ciWordType   ciDataA,
  input  ciWordType   ciDataB,
  output logic        ciDone,
  output logic        cpuReset,
  output ciWordType   ciResult
);

  logic      swapStart;
  logic      freqStart;
  logic      delayStart;
  logic      swapDone;
  logic      freqDone;
  logic      delayDone;
  ciWordType swapResult;
  ciWordType freqResult;
  ciWordType delayResult;

  resetSequencer i_resetSequencer (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .cpuReset      (cpuReset)
  );

  ciDispatcher i_ciDispatcher (
    .s_systemClock (s_systemClock),
    .cpuReset      (cpuReset),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .swapStart     (swapStart),
    .freqStart     (freqStart),
    .delayStart    (delayStart),
    .swapDone      (swapDone),
    .freqDone      (freqDone),
    .delayDone     (delayDone),
    .swapResult    (swapResult),
    .freqResult    (freqResult),
    .delayResult   (delayResult),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  swapByte i_swapByte (
    .swapStart  (swapStart),
    .ciDataA    (ciDataA),
    .ciDataB    (ciDataB),
    .swapDone   (swapDone),
    .swapResult (swapResult)
  );

  processorId i_processorId (
    .s_systemClock (s_systemClock),
    .cpuReset      (cpuReset),
    .clock50MHz    (clock50MHz),
    .biosBypass    (biosBypass),
    .freqStart     (freqStart),
    .freqDone      (freqDone),
    .freqResult    (freqResult)
  );

  delayMicro i_delayMicro (
    .s_systemClock (s_systemClock),
    .cpuReset      (cpuReset),
    .clock12MHz    (clock12MHz),
    .delayStart    (delayStart),
    .ciDataA       (ciDataA),
    .delayDone     (delayDone),
    .delayResult   (delayResult)
  );

endmodule

/* source/delayMicro.sv */
`timescale 1ns/1ps

module delayMicro import ciPackage::*; (
  input  logic      s_systemClock,
  input  logic      cpuReset,
  input  logic      clock12MHz,
  input  logic      delayStart,
  input  ciWordType ciDataA,
  output logic      delayDone,
  output ciWordType delayResult
);

  logic [delayRefCountBits-1:0] divCountReg;
  logic                         tickFlagReg;
  logic [2:0]                   tickSyncReg;
  logic                         microTick;
  logic [delayDelayBits-1:0]    remainingReg;
  logic                         activeReg;
  logic                         alignedReg;

  // Every level change of the flag marks one microsecond.
  always_ff @(posedge clock12MHz or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      divCountReg <= '0;
      tickFlagReg <= 1'b0;
    end else if (divCountReg == delayRefCountBits'(delayRefCyclesPerMicro - 1)) begin
      divCountReg <= '0;
      tickFlagReg <= ~tickFlagReg;
    end else begin
      divCountReg <= divCountReg + 1'b1;
    end
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      tickSyncReg <= '0;
    end else begin
      tickSyncReg <= {tickSyncReg[1:0], tickFlagReg};
    end
  end

  assign microTick = tickSyncReg[2] ^ tickSyncReg[1];

  // The first tick after a start only lines the count up with the
  // microsecond grid, so a delay never ends early.
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      activeReg  <= 1'b0;
      alignedReg <= 1'b0;
    end else if (delayStart == 1'b1) begin
      activeReg  <= 1'b1;
      alignedReg <= 1'b0;
    end else if (delayDone == 1'b1) begin
      activeReg <= 1'b0;
    end else if (microTick == 1'b1) begin
      alignedReg <= 1'b1;
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (delayStart == 1'b1) begin
      remainingReg <= ciDataA[delayDelayBits-1:0];
    end else if ((activeReg & alignedReg & microTick) == 1'b1 && remainingReg != '0) begin
      remainingReg <= remainingReg - 1'b1;
    end
  end

  assign delayDone   = activeReg & (remainingReg == '0);
  assign delayResult = '0;  // The delay returns no value.

endmodule

/* source/processorId.sv */
`timescale 1ns/1ps

module processorId import ciPackage::*; (
  input  logic      s_systemClock,
  input  logic      cpuReset,
  input  logic      clock50MHz,
  input  logic      biosBypass,
  input  logic      freqStart,
  output logic      freqDone,
  output ciWordType freqResult
);

  logic [freqRefCountBits-1:0] refCountReg;
  logic                        windowFlagReg;
  logic [2:0]                  windowSyncReg;
  logic                        windowEdge;
  logic [freqFieldBits-1:0]    sysCountReg;
  logic [freqFieldBits-1:0]    freqReg;
  logic                        firstEdgeSeenReg;

  // Reference side. The flag changes level once per window.
  always_ff @(posedge clock50MHz or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      refCountReg   <= '0;
      windowFlagReg <= 1'b0;
    end else if (refCountReg == freqRefCountBits'(freqWindowRefCycles - 1)) begin
      refCountReg   <= '0;
      windowFlagReg <= ~windowFlagReg;
    end else begin
      refCountReg <= refCountReg + 1'b1;
    end
  end

  // Bits 0 and 1 synchronize, bit 2 remembers the previous level.
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      windowSyncReg <= '0;
    end else begin
      windowSyncReg <= {windowSyncReg[1:0], windowFlagReg};
    end
  end

  assign windowEdge = windowSyncReg[2] ^ windowSyncReg[1];

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      sysCountReg      <= '0;
      freqReg          <= '0;
      firstEdgeSeenReg <= 1'b0;
    end else if (windowEdge == 1'b1) begin
      sysCountReg      <= freqFieldBits'(1);  // This cycle already belongs to the next window.
      firstEdgeSeenReg <= 1'b1;
      // The window before the first edge started at reset and is not a full one.
      if (firstEdgeSeenReg == 1'b1) begin
        freqReg <= freqFieldBits'(sysCountReg * freqHzPerCount);
      end
    end else begin
      sysCountReg <= sysCountReg + 1'b1;
    end
  end

  assign freqDone   = freqStart;
  assign freqResult = (freqStart == 1'b1) ? {biosBypass, processorIdValue, freqReg} : '0;

endmodule

/* source/swapByte.sv */
`timescale 1ns/1ps

module swapByte import ciPackage::*; (
  input  logic      swapStart,
  input  ciWordType ciDataA,
  input  ciWordType ciDataB,
  output logic      swapDone,
  output ciWordType swapResult
);

  ciWordType reversedWord;
  ciWordType halfSwappedWord;

  assign reversedWord = {ciDataA[7:0],
                         ciDataA[15:8],
                         ciDataA[23:16],
                         ciDataA[31:24]};

  // Bytes trade places inside each halfword, the halfwords stay put.
  assign halfSwappedWord = {ciDataA[23:16],
                            ciDataA[31:24],
                            ciDataA[7:0],
                            ciDataA[15:8]};

  assign swapDone = swapStart;

  always_comb begin
    if (swapStart == 1'b0) begin
      swapResult = '0;  // Keeps the OR merge in the dispatcher clean.
    end else if (ciDataB[0] == 1'b1) begin
      swapResult = halfSwappedWord;
    end else begin
      swapResult = reversedWord;
    end
  end

endmodule

/* source/ciDispatcher.sv */
`timescale 1ns/1ps

module ciDispatcher import ciPackage::*; (
  input  logic        s_systemClock,
  input  logic        cpuReset,
  input  logic        ciStart,
  input  ciOpcodeType ciN,
  output logic        swapStart,
  output logic        freqStart,
  output logic        delayStart,
  input  logic        swapDone,
  input  logic        freqDone,
  input  logic        delayDone,
  input  ciWordType   swapResult,
  input  ciWordType   freqResult,
  input  ciWordType   delayResult,
  output logic        ciDone,
  output ciWordType   ciResult
);

  logic delayBusyReg;
  logic startAllowed;
  logic unknownDone;

  // A delay in flight blocks further starts.
  assign startAllowed = ciStart & ~delayBusyReg;

  always_comb begin
    swapStart   = 1'b0;
    freqStart   = 1'b0;
    delayStart  = 1'b0;
    unknownDone = 1'b0;
    if (startAllowed == 1'b1) begin
      case (ciN)
        ciSwapByte: swapStart  = 1'b1;
        ciCpuFreq:  freqStart  = 1'b1;
        ciDelay:    delayStart = 1'b1;
        default:    unknownDone = 1'b1;  // Answered at once so the processor never hangs.
      endcase
    end
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset == 1'b1) begin
      delayBusyReg <= 1'b0;
    end else if (delayStart == 1'b1) begin
      delayBusyReg <= 1'b1;
    end else if (delayDone == 1'b1) begin
      delayBusyReg <= 1'b0;
    end
  end

  // Every unit keeps its result at zero outside its own done cycle.
  assign ciDone   = swapDone | freqDone | delayDone | unknownDone;
  assign ciResult = swapResult | freqResult | delayResult;

endmodule

/* source/resetSequencer.sv */
`timescale 1ns/1ps

module resetSequencer import ciPackage::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);

  logic [resetCounterBits-1:0] resetCountReg;

  // Counts up after lock and freezes once the top bit is set.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (s_pllLocked == 1'b0) begin
      resetCountReg <= '0;
    end else if (resetCountReg[resetCounterBits-1] == 1'b0) begin
      resetCountReg <= resetCountReg + 1'b1;
    end
  end

  assign cpuReset = ~resetCountReg[resetCounterBits-1];  // High until the count is done.

endmodule

/* source/ciPackage.sv */
package ciPackage;

  // Operand and result word of the custom-instruction port.
  typedef logic [31:0] ciWordType;

  // Instruction numbers served by this subsystem.
  typedef enum logic [7:0] {
    ciSwapByte = 8'd1,
    ciCpuFreq  = 8'd4,
    ciDelay    = 8'd6
  } ciOpcodeType;

  // The processor leaves reset when the top bit of this counter sets.
  localparam int resetCounterBits = 5;

  // One microsecond of the 12 MHz reference.
  localparam int delayRefCyclesPerMicro = 12;

  // A 10 us measurement window on the 50 MHz reference.
  localparam int freqWindowRefCycles = 500;

  // One system clock per 10 us window stands for 100 kHz.
  localparam int freqHzPerCount = 100000;

  localparam logic [2:0] processorIdValue = 3'd1;

  localparam int freqFieldBits = 28;

  localparam int delayDelayBits = 32;

  // Widths of the dividers in the reference clock domains.
  localparam int freqRefCountBits  = $clog2(freqWindowRefCycles);
  localparam int delayRefCountBits = $clog2(delayRefCyclesPerMicro);

endpackage
